/* rv_isa_pkg.sv */
// RV32I base encodings only; compressed and privileged encodings are not described
package rv_isa_pkg;

    localparam int XLEN       = 32; // Integer register width
    localparam int REG_ADDR_W = 5;  // 32 architectural registers

    // Major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011
    } opcode_e;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // OP and OP_IMM groups, bit 30 splits ADD/SUB and SRL/SRA
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

endpackage

/* rv_ctrl_pkg.sv */
// Internal control encodings; values are arbitrary and never leave the design
package rv_ctrl_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU,  // OP, OP_IMM, AUIPC
        WB_IMM,  // LUI
        WB_PC4,  // JAL, JALR link
        WB_NONE  // No register write
    } wb_src_e;

endpackage

/* decoded_if.sv */
// Decoded fields carry no handshake; they follow the instruction word combinationally
`timescale 1ns/1ps

interface decoded_if;

    rv_isa_pkg::opcode_e                    op;       // Major opcode
    logic [2:0]                             funct3;
    logic                                   funct7b5; // Instruction bit 30
    logic [rv_isa_pkg::REG_ADDR_W-1:0]      rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]      rs2;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]      rd;
    logic [4:0]                             sh;       // Shift amount, OP_IMM shifts only
    logic [rv_isa_pkg::XLEN-1:0]            imm;      // Sign-extended immediate

    // Decoder side
    modport src (output op, funct3, funct7b5, rs1, rs2, rd, sh, imm);

    // Execute side
    modport dst (input op, funct3, funct7b5, rs1, rs2, rd, sh, imm);

endinterface

/* rv_decoder.sv */
// RV32I field extraction only; unknown opcodes give a zero immediate and are not flagged here
`timescale 1ns/1ps

module rv_decoder (
    input  logic [31:0] i_inst, // Instruction word
    decoded_if.src      dec     // Decoded fields
);

    // Immediate by instruction format
    always_comb begin
        case (dec.op)
            rv_isa_pkg::OPCODE_BRANCH:  // B format
                dec.imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

            rv_isa_pkg::OPCODE_JAL:     // J format
                dec.imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

            rv_isa_pkg::OPCODE_JALR,
            rv_isa_pkg::OPCODE_OP_IMM,
            rv_isa_pkg::OPCODE_LOAD:    // I format
                dec.imm = {{20{i_inst[31]}}, i_inst[31:20]};

            rv_isa_pkg::OPCODE_STORE:   // S format
                dec.imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};

            rv_isa_pkg::OPCODE_LUI,
            rv_isa_pkg::OPCODE_AUIPC:   // U format
                dec.imm = {i_inst[31:12], 12'b0};

            default:
                dec.imm = '0;
        endcase
    end

    // Shift amount, only for the immediate shift forms
    always_comb begin
        dec.sh = '0;
        if (dec.op == rv_isa_pkg::OPCODE_OP_IMM) begin
            case (dec.funct3)
                rv_isa_pkg::F3_SLL,
                rv_isa_pkg::F3_SRL_SRA:
                    dec.sh = i_inst[24:20];

                default:
                    dec.sh = '0;
            endcase
        end
    end

    // Fixed position fields
    always_comb begin
        dec.op       = rv_isa_pkg::opcode_e'(i_inst[6:0]);
        dec.funct3   = i_inst[14:12];
        dec.funct7b5 = i_inst[30];   // SUB and SRA/SRAI select
        dec.rs1      = i_inst[19:15];
        dec.rs2      = i_inst[24:20];
        dec.rd       = i_inst[11:7];
    end

endmodule

/* reg_file.sv */
// Reads are combinational, so a write and a read of one register in a cycle return the old value
`timescale 1ns/1ps

module reg_file (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [4:0]  i_rs1_addr,
    input  logic [4:0]  i_rs2_addr,
    output logic [31:0] o_rs1_data,
    output logic [31:0] o_rs2_data,
    input  logic        i_wr_en,
    input  logic [4:0]  i_wr_addr,
    input  logic [31:0] i_wr_data
);

    logic [31:0] regs [31:1]; // x0 has no storage

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != 5'd0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // x0 always reads as zero
    always_comb begin
        o_rs1_data = (i_rs1_addr == 5'd0) ? 32'd0 : regs[i_rs1_addr];
        o_rs2_data = (i_rs2_addr == 5'd0) ? 32'd0 : regs[i_rs2_addr];
    end

endmodule

/* alu.sv */
// Shift amounts use only the low 5 bits of the second operand
`timescale 1ns/1ps

module alu (
    input  rv_ctrl_pkg::alu_op_e i_op,
    input  logic [31:0]          i_a,
    input  logic [31:0]          i_b,
    output logic [31:0]          o_result
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = i_b[4:0];
    assign lt_s  = $signed(i_a) < $signed(i_b);
    assign lt_u  = i_a < i_b;

    always_comb begin
        case (i_op)
            rv_ctrl_pkg::ALU_ADD:  o_result = i_a + i_b;
            rv_ctrl_pkg::ALU_SUB:  o_result = i_a - i_b;
            rv_ctrl_pkg::ALU_SLL:  o_result = i_a << shamt;
            rv_ctrl_pkg::ALU_SLT:  o_result = {31'd0, lt_s};
            rv_ctrl_pkg::ALU_SLTU: o_result = {31'd0, lt_u};
            rv_ctrl_pkg::ALU_XOR:  o_result = i_a ^ i_b;
            rv_ctrl_pkg::ALU_SRL:  o_result = i_a >> shamt;
            rv_ctrl_pkg::ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt); // Sign fill
            rv_ctrl_pkg::ALU_OR:   o_result = i_a | i_b;
            rv_ctrl_pkg::ALU_AND:  o_result = i_a & i_b;
            default:               o_result = '0;
        endcase
    end

endmodule

/* exec_ctrl.sv */
// LOAD, STORE and unknown opcodes only advance the PC; misaligned targets are not trapped
`timescale 1ns/1ps

module exec_ctrl #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_valid,
    decoded_if.dst               dec,
    input  logic [31:0]          i_rs1_data,
    input  logic [31:0]          i_rs2_data,
    output rv_ctrl_pkg::alu_op_e o_alu_op,
    output logic [31:0]          o_alu_a,
    output logic [31:0]          o_alu_b,
    input  logic [31:0]          i_alu_result,
    output logic                 o_wr_en,
    output logic [4:0]           o_wr_addr,
    output logic [31:0]          o_wr_data,
    output logic [31:0]          o_pc,
    output logic                 o_wb_valid,
    output logic [4:0]           o_wb_rd,
    output logic [31:0]          o_wb_data,
    output logic                 o_illegal
);

    rv_ctrl_pkg::wb_src_e wb_src;
    logic                 illegal;
    logic                 taken;
    logic                 shift_imm; // OP_IMM shift forms take the shamt
    logic [31:0]          pc_plus4;
    logic [31:0]          pc_plus_imm;
    logic [31:0]          next_pc;
    logic [31:0]          wb_data;

    assign pc_plus4    = o_pc + 32'd4;
    assign pc_plus_imm = o_pc + dec.imm;
    assign shift_imm   = (dec.funct3 == rv_isa_pkg::F3_SLL) ||
                         (dec.funct3 == rv_isa_pkg::F3_SRL_SRA);

    // ALU operation from funct3, bit 30 only where the encoding defines it
    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::F3_ADD_SUB: o_alu_op = (dec.op == rv_isa_pkg::OPCODE_OP && dec.funct7b5)
                                               ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     o_alu_op = rv_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     o_alu_op = rv_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    o_alu_op = rv_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     o_alu_op = rv_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: o_alu_op = dec.funct7b5 ? rv_ctrl_pkg::ALU_SRA
                                                            : rv_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      o_alu_op = rv_ctrl_pkg::ALU_OR;
            default:                o_alu_op = rv_ctrl_pkg::ALU_AND;
        endcase
        // AUIPC and JALR use the ALU as an adder
        if (dec.op != rv_isa_pkg::OPCODE_OP && dec.op != rv_isa_pkg::OPCODE_OP_IMM) begin
            o_alu_op = rv_ctrl_pkg::ALU_ADD;
        end
    end

    // Operand selection
    always_comb begin
        o_alu_a = (dec.op == rv_isa_pkg::OPCODE_AUIPC) ? o_pc : i_rs1_data;
        if (dec.op == rv_isa_pkg::OPCODE_OP) begin
            o_alu_b = i_rs2_data;
        end else if (dec.op == rv_isa_pkg::OPCODE_OP_IMM && shift_imm) begin
            o_alu_b = {27'd0, dec.sh};
        end else begin
            o_alu_b = dec.imm;
        end
    end

    // Branch comparator on register data
    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::F3_BEQ:  taken = (i_rs1_data == i_rs2_data);
            rv_isa_pkg::F3_BNE:  taken = (i_rs1_data != i_rs2_data);
            rv_isa_pkg::F3_BLT:  taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            rv_isa_pkg::F3_BGE:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            rv_isa_pkg::F3_BLTU: taken = (i_rs1_data < i_rs2_data);
            rv_isa_pkg::F3_BGEU: taken = (i_rs1_data >= i_rs2_data);
            default:             taken = 1'b0; // Reserved conditions fall through
        endcase
    end

    // Next PC and write-back source per opcode
    always_comb begin
        next_pc = pc_plus4;
        wb_src  = rv_ctrl_pkg::WB_NONE;
        illegal = 1'b0;
        case (dec.op)
            rv_isa_pkg::OPCODE_OP,
            rv_isa_pkg::OPCODE_OP_IMM,
            rv_isa_pkg::OPCODE_AUIPC:  wb_src = rv_ctrl_pkg::WB_ALU;
            rv_isa_pkg::OPCODE_LUI:    wb_src = rv_ctrl_pkg::WB_IMM;
            rv_isa_pkg::OPCODE_JAL: begin
                wb_src  = rv_ctrl_pkg::WB_PC4;
                next_pc = pc_plus_imm;
            end
            rv_isa_pkg::OPCODE_JALR: begin
                wb_src  = rv_ctrl_pkg::WB_PC4;
                next_pc = {i_alu_result[31:1], 1'b0}; // rs1 + imm, bit 0 cleared
            end
            rv_isa_pkg::OPCODE_BRANCH: next_pc = taken ? pc_plus_imm : pc_plus4;
            default:                   illegal = 1'b1; // LOAD, STORE and the rest
        endcase
    end

    always_comb begin
        case (wb_src)
            rv_ctrl_pkg::WB_IMM: wb_data = dec.imm;
            rv_ctrl_pkg::WB_PC4: wb_data = pc_plus4;
            default:             wb_data = i_alu_result;
        endcase
    end

    // Register write port, committed at the same edge as the PC
    assign o_wr_en   = i_valid && (wb_src != rv_ctrl_pkg::WB_NONE) && (dec.rd != 5'd0);
    assign o_wr_addr = dec.rd;
    assign o_wr_data = wb_data;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc       <= RESET_PC;
            o_wb_valid <= 1'b0;
            o_illegal  <= 1'b0;
        end else if (i_valid) begin
            o_pc       <= next_pc;
            o_wb_valid <= o_wr_en;
            o_illegal  <= illegal;
            o_wb_rd    <= dec.rd;
            o_wb_data  <= wb_data;
        end else begin
            o_wb_valid <= 1'b0; // Idle cycle, report stays but pulses drop
            o_illegal  <= 1'b0;
        end
    end

endmodule

/* rv_exec_top.sv */
// One instruction per valid cycle with no back-pressure; RESET_PC must be word aligned
`timescale 1ns/1ps

module rv_exec_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_valid,
    input  logic [31:0] i_inst,
    output logic [31:0] o_pc,
    output logic        o_wb_valid,
    output logic [4:0]  o_wb_rd,
    output logic [31:0] o_wb_data,
    output logic        o_illegal
);

    decoded_if dec_bus ();

    logic [31:0]          rs1_data;
    logic [31:0]          rs2_data;
    rv_ctrl_pkg::alu_op_e alu_op;
    logic [31:0]          alu_a;
    logic [31:0]          alu_b;
    logic [31:0]          alu_result;
    logic                 wr_en;
    logic [4:0]           wr_addr;
    logic [31:0]          wr_data;

    rv_decoder u_decoder (
        .i_inst (i_inst),
        .dec    (dec_bus.src)
    );

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (dec_bus.rs1),
        .i_rs2_addr (dec_bus.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data)
    );

    alu u_alu (
        .i_op     (alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    exec_ctrl #(
        .RESET_PC (RESET_PC)
    ) u_exec_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .dec          (dec_bus.dst),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_alu_op     (alu_op),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .i_alu_result (alu_result),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data),
        .o_pc         (o_pc),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data),
        .o_illegal    (o_illegal)
    );

endmodule

/* tb_rv_exec.sv */
// Random RV32I stream from a fixed seed; the model assumes RESET_PC stays at its default of zero
`timescale 1ns/1ps

module tb_rv_exec;

    localparam int CYCLES     = 3000;
    localparam int EDGE_LIMIT = 40;       // 1 ns polls before a missing clock edge is reported

    logic        i_clk;
    logic        i_rst;
    logic        i_valid;
    logic [31:0] i_inst;
    logic [31:0] o_pc;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;
    logic        o_illegal;

    logic [31:0] rng_state;
    logic [31:0] model_regs [32];         // Architectural registers with x0 kept at zero
    logic [31:0] model_pc;
    logic        exp_wb_valid;
    logic [4:0]  exp_wb_rd;
    logic [31:0] exp_wb_data;
    logic        exp_illegal;
    int          cycle_cnt = 0;
    int          errors;
    int          checks;

    rv_exec_top dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_valid    (i_valid),
        .i_inst     (i_inst),
        .o_pc       (o_pc),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_illegal  (o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cycle_cnt++;

    // xorshift32
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Polls on half-ns offsets so the exit never races the clock edge
    task automatic wait_edge();
        int start;
        int polls;
        start = cycle_cnt;
        polls = 0;
        #0.5;
        while (cycle_cnt == start && polls < EDGE_LIMIT) begin
            #1;
            polls++;
        end
        if (cycle_cnt == start) begin
            $display("Timeout: no rising clock edge within %0d ns", EDGE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    endtask

    // RV32I result of the OP group; alt selects SUB or SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{a[31]}})
                                : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        logic [31:0] imm;
        logic        wide;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r    = next_rand();
        imm  = next_rand();
        wide = r[13] && r[14];            // A quarter of the words reach x8 to x31
        rd   = {wide ? r[16:15] : 2'b00, r[2:0]}; // Small register set keeps dependencies frequent
        rs1  = {wide ? r[18:17] : 2'b00, r[5:3]};
        rs2  = {wide ? r[20:19] : 2'b00, r[8:6]};
        f3   = r[11:9];
        f7   = (r[12] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        case (r[31:28])
            0, 1, 2: return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPCODE_OP};
            3, 4, 5: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    return {f7, imm[4:0], rs1, f3, rd, rv_isa_pkg::OPCODE_OP_IMM};
                end
                return {imm[11:0], rs1, f3, rd, rv_isa_pkg::OPCODE_OP_IMM};
            end
            6, 14: return {imm[31:12], rd, rv_isa_pkg::OPCODE_LUI};
            7:     return {imm[31:12], rd, rv_isa_pkg::OPCODE_AUIPC};
            8, 9: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;         // Reserved 010 and 011 become BLTU and BGEU
                end
                imm[1:0] = 2'b00;
                return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                        rv_isa_pkg::OPCODE_BRANCH};
            end
            10: begin
                imm[1:0] = 2'b00;
                return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPCODE_JAL};
            end
            11, 15: return {imm[11:0], rs1, 3'b000, rd, rv_isa_pkg::OPCODE_JALR};
            12:     return {imm[11:0], rs1, 3'b010, rd, rv_isa_pkg::OPCODE_LOAD};
            default: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::OPCODE_STORE};
        endcase
    endfunction

    // Executes one accepted instruction and sets the outputs expected after the edge
    task automatic model_step(input logic [31:0] inst);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        writes;
        logic        cond;
        rd      = inst[11:7];
        f3      = inst[14:12];
        a       = model_regs[inst[19:15]];
        b       = model_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        writes  = 1'b1;
        cond    = 1'b0;
        res     = model_pc + 32'd4;       // Link value for jumps
        next_pc = model_pc + 32'd4;
        exp_illegal = 1'b0;
        case (inst[6:0])
            rv_isa_pkg::OPCODE_OP:     res = alu_ref(f3, inst[30], a, b);
            rv_isa_pkg::OPCODE_OP_IMM: res = alu_ref(f3, inst[30] && f3 == 3'b101, a, imm_i);
            rv_isa_pkg::OPCODE_LUI:    res = {inst[31:12], 12'b0};
            rv_isa_pkg::OPCODE_AUIPC:  res = model_pc + {inst[31:12], 12'b0};
            rv_isa_pkg::OPCODE_JAL:    next_pc = model_pc + imm_j;
            rv_isa_pkg::OPCODE_JALR:   next_pc = (a + imm_i) & ~32'd1;
            rv_isa_pkg::OPCODE_BRANCH: begin
                writes = 1'b0;
                case (f3)
                    3'b000:  cond = (a == b);
                    3'b001:  cond = (a != b);
                    3'b100:  cond = ($signed(a) < $signed(b));
                    3'b101:  cond = ($signed(a) >= $signed(b));
                    3'b110:  cond = (a < b);
                    default: cond = (a >= b);
                endcase
                if (cond) begin
                    next_pc = model_pc + imm_b;
                end
            end
            default: begin                // LOAD and STORE
                writes      = 1'b0;
                exp_illegal = 1'b1;
            end
        endcase
        exp_wb_valid = writes && (rd != 5'd0);
        if (exp_wb_valid) begin
            exp_wb_rd       = rd;
            exp_wb_data     = res;
            model_regs[rd]  = res;
        end
        model_pc = next_pc;
    endtask

    initial begin
        logic [31:0] inst;
        logic        valid;
        rng_state    = 32'hda305cb8;
        errors       = 0;
        checks       = 0;
        i_rst        = 1'b1;
        i_valid      = 1'b0;
        i_inst       = 32'd0;
        model_pc     = 32'd0;
        exp_wb_valid = 1'b0;
        exp_wb_rd    = 5'd0;
        exp_wb_data  = 32'd0;
        exp_illegal  = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        repeat (16) begin
            wait_edge();
        end
        #1.5;
        i_rst = 1'b0;
        check("o_pc", 32'd0, o_pc);       // State straight out of reset
        check("o_wb_valid", 32'd0, o_wb_valid);
        check("o_illegal", 32'd0, o_illegal);

        for (int cyc = 0; cyc < CYCLES; cyc++) begin
            valid   = (next_rand() % 10) < 8;   // About 80% busy cycles
            inst    = gen_inst();
            i_valid = valid;
            i_inst  = inst;
            if (valid) begin
                model_step(inst);
            end else begin
                exp_wb_valid = 1'b0;      // PC holds on an idle cycle
                exp_illegal  = 1'b0;
            end
            wait_edge();
            check("o_pc", model_pc, o_pc);
            check("o_wb_valid", exp_wb_valid, o_wb_valid);
            check("o_illegal", exp_illegal, o_illegal);
            if (exp_wb_valid) begin
                check("o_wb_rd", exp_wb_rd, o_wb_rd);
                check("o_wb_data", exp_wb_data, o_wb_data);
            end
            #1.5;
        end
        i_valid = 1'b0;

        $display("Checked %0d values over %0d cycles, %0d errors", checks, CYCLES, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
rv_isa_pkg.sv
rv_ctrl_pkg.sv
decoded_if.sv
rv_decoder.sv
reg_file.sv
alu.sv
exec_ctrl.sv
rv_exec_top.sv
tb_rv_exec.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - rv_isa_pkg.sv
  - rv_ctrl_pkg.sv
  - decoded_if.sv
  - rv_decoder.sv
  - reg_file.sv
  - alu.sv
  - exec_ctrl.sv
  - rv_exec_top.sv
  - target: test
    files:
      - tb_rv_exec.sv
